/* filelist.f */
+incdir+.
f100l_pkg.sv
wb_master.sv
alu.sv
bit_unit.sv
instr_sequencer.sv
f100l_top.sv
tb_f100l.sv

/* tb_f100l_model.svh */
// Memory answered by the bus slave, and the copy the reference model runs on.
logic [15:0] mem     [0:65535];
logic [15:0] ref_mem [0:65535];
logic [15:0] load_adr;

// Store writes predicted by the reference model, in program order.
logic [15:0] exp_adr [$];
logic [15:0] exp_dat [$];

localparam int          max_instr = 64;
localparam logic [15:0] halt_word = 16'h0400;

// Every word gets a value tied to its whole address.
task automatic clear_memory();
  for (int a = 0; a < 65536; a++)
    mem[a] = a[15:0] ^ 16'hc3a5 ^ {a[7:0], a[15:8]};
  load_adr = prog_base;
endtask

task automatic emit(input logic [15:0] w);
  mem[load_adr] = w;
  load_adr = load_adr + 16'd1;
endtask

// Short address form. A zero address selects the inline operand.
function automatic logic [15:0] mem_op(input logic [3:0] opc, input int n);
  return {opc, 1'b0, n[10:0]};
endfunction

task automatic emit_imm(input logic [3:0] opc, input logic [15:0] d);
  emit(mem_op(opc, 0));
  emit(d);
endtask

function automatic logic [15:0] bit_op(input logic [1:0] r, input logic [1:0] s,
                                       input logic [1:0] j, input int b);
  return {4'h0, 2'b00, r, s, j, b[3:0]};
endfunction

// One step of a shift. Kind 11 rotates, 10 is logical and the rest arithmetic.
function automatic logic [15:0] shift_once(input logic [15:0] w, input logic left,
                                           input logic [1:0] kind);
  if (left)
    return (kind == 2'b11) ? {w[14:0], w[15]} : {w[14:0], 1'b0};
  else if (kind == 2'b11)
    return {w[0], w[15:1]};
  else if (kind == 2'b10)
    return {1'b0, w[15:1]};
  else
    return {w[15], w[15:1]};
endfunction

// Runs the loaded program on its own memory copy. Returns 1 when HALT is reached.
function automatic bit ref_run(input logic [15:0] start);
  logic [15:0] pc;
  logic [15:0] acc;
  logic [15:0] cr;
  logic [15:0] ir;
  logic [15:0] ea;
  logic [15:0] opd;
  logic [15:0] w;
  logic [16:0] wide;
  logic [1:0]  s;
  logic [1:0]  j;
  logic [3:0]  b;
  logic        hit;
  logic        done;
  int          steps;
  exp_adr.delete();
  exp_dat.delete();
  for (int a = 0; a < 65536; a++)
    ref_mem[a] = mem[a];
  pc = start;
  acc = 16'd0;
  cr = 16'd0;
  steps = 0;
  done = 1'b0;
  while (!done && steps < max_instr)
  begin
    ir = ref_mem[pc];
    pc = pc + 16'd1;
    steps++;
    case (ir[15:12])
      4'h0:
      begin
        if (ir[11:10] == 2'b01)
          done = 1'b1;
        else if (ir[11:10] == 2'b00)
        begin
          s = ir[7:6];
          j = ir[5:4];
          b = ir[3:0];
          w = (ir[9:8] == 2'b01) ? cr : acc;
          hit = 1'b0;
          if (!s[1])
          begin
            for (int k = 0; k < b; k++)
              w = shift_once(w, s[0], j);
          end
          else
          begin
            hit = (w[b] == j[0]);
            if (s == 2'b11 || (hit && j[1]))
              w[b] = ~j[0];
          end
          if (ir[9:8] == 2'b01)
            cr = w;
          else
            acc = w;
          // Shifts report sign and zero of the new word.
          if (!s[1])
          begin
            cr[cr_s_bit] = w[15];
            cr[cr_z_bit] = (w == 16'd0);
          end
          if (s == 2'b10)
          begin
            ea = ref_mem[pc];
            pc = pc + 16'd1;
            if (hit)
              pc = ea;
          end
        end
      end
      op_sjm:
        pc = pc + acc;
      op_sto, op_ads, op_sbs, op_lda, op_add, op_sub, op_cmp, op_and, op_neq, op_jmp:
      begin
        if (ir[10:0] != 11'd0)
          ea = {5'd0, ir[10:0]};
        else
        begin
          ea = pc;
          pc = pc + 16'd1;
        end
        opd = ref_mem[ea];
        case (ir[15:12])
          op_add, op_ads:
            wide = {1'b0, opd} + {1'b0, acc} + (cr[cr_m_bit] & cr[cr_c_bit]);
          // Adds the two's complement of the accumulator. Borrow in only with M set.
          op_sub, op_sbs, op_cmp:
            wide = {1'b0, opd} + {1'b1, ~acc} + (cr[cr_m_bit] ? cr[cr_c_bit] : 1'b1);
          op_and:
            wide = {1'b0, acc & opd};
          op_neq:
            wide = {1'b0, acc ^ opd};
          op_sto:
            wide = {1'b0, acc};
          default:
            wide = {1'b0, opd};
        endcase
        if (ir[15:12] != op_lda)
          cr[cr_c_bit] = wide[16];
        cr[cr_s_bit] = wide[15];
        cr[cr_z_bit] = (wide[15:0] == 16'd0);
        case (ir[15:12])
          op_add, op_ads:
            cr[cr_v_bit] = (acc[15] == opd[15]) && (wide[15] != acc[15]);
          op_sub, op_sbs, op_cmp:
            cr[cr_v_bit] = (acc[15] != opd[15]) && (wide[15] != opd[15]);
          default:
            cr[cr_v_bit] = cr[cr_v_bit];
        endcase
        case (ir[15:12])
          op_sto, op_ads, op_sbs:
          begin
            ref_mem[ea] = wide[15:0];
            exp_adr.push_back(ea);
            exp_dat.push_back(wide[15:0]);
          end
          op_jmp:
            pc = wide[15:0];
          op_cmp:
            acc = acc;
          default:
            acc = wide[15:0];
        endcase
      end
      default:
        pc = pc;
    endcase
  end
  return done;
endfunction

/* tb_f100l.sv */
`timescale 1ns/1ps

module tb_f100l;
  import f100l_pkg::*;

  localparam logic [15:0] prog_base  = 16'h2000;
  localparam int          clk_period = 4;
  localparam int          test_count = 6;

  logic        raw_clk;
  logic        button_reset;
  logic        button_halt;
  logic        wb_ack;
  logic [15:0] wb_dat_r;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [15:0] wb_adr;
  logic [15:0] wb_dat_w;
  logic        halted;

  integer      seed;
  int          error_count;
  int          pass_count;
  int          fail_count;
  int          exp_idx;
  int          wait_left;
  logic        in_cycle;
  logic [15:0] obs_adr [$];
  logic [15:0] obs_dat [$];
  logic [15:0] seen_adr;
  logic [15:0] seen_dat;

  `include "tb_f100l_model.svh"

  f100l_top #(
    .reset_pc (prog_base)
  ) f100l_top_i (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .button_halt  (button_halt),
    .wb_ack       (wb_ack),
    .wb_dat_r     (wb_dat_r),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w),
    .halted       (halted)
  );

  initial
  begin
    raw_clk = 1'b0;
    forever
      #(clk_period / 2) raw_clk = ~raw_clk;
  end

  // Budget of 40 cycles per instruction plus reset and idle time per test.
  initial
  begin
    #(test_count * (max_instr * 40 + 200) * clk_period);
    $display("Timeout: the core did not finish the tests in time.");
    $display("Test failed");
    $finish;
  end

  function automatic logic [15:0] rand_word();
    int r;
    r = $random(seed);
    return r[15:0];
  endfunction

  // Wishbone slave with 0 to 3 wait states and a one-cycle ack.
  always @(negedge raw_clk)
  begin
    if (wb_ack)
    begin
      wb_ack = 1'b0;
      in_cycle = 1'b0;
    end
    else if (wb_cyc && wb_stb)
    begin
      if (!in_cycle)
      begin
        in_cycle = 1'b1;
        wait_left = $random(seed) & 3;
      end
      if (wait_left == 0)
      begin
        wb_ack = 1'b1;
        if (wb_we)
        begin
          mem[wb_adr] = wb_dat_w;
          obs_adr.push_back(wb_adr);
          obs_dat.push_back(wb_dat_w);
        end
        else
          wb_dat_r = mem[wb_adr];
      end
      else
        wait_left--;
    end
  end

  // Each observed write against the next predicted one.
  always @(posedge raw_clk)
  begin
    while (obs_adr.size() > 0)
    begin
      seen_adr = obs_adr.pop_front();
      seen_dat = obs_dat.pop_front();
      assert (exp_idx < exp_adr.size())
      else
      begin
        $display("Extra write of %h to %h at %0t, none left in the reference list.",
                 seen_dat, seen_adr, $time);
        error_count++;
      end
      if (exp_idx < exp_adr.size())
      begin
        assert (seen_adr == exp_adr[exp_idx])
        else
        begin
          $display("mismatch at %0t: wb_adr expected %h got %h",
                   $time, exp_adr[exp_idx], seen_adr);
          error_count++;
        end
        assert (seen_dat == exp_dat[exp_idx])
        else
        begin
          $display("mismatch at %0t: wb_dat_w expected %h got %h",
                   $time, exp_dat[exp_idx], seen_dat);
          error_count++;
        end
      end
      exp_idx++;
    end
  end

  task automatic run_test(input string name, input bit stop_early);
    int errors_before;
    bit reaches_halt;
    errors_before = error_count;
    reaches_halt = ref_run(prog_base);
    @(negedge raw_clk);
    button_reset = 1'b0;
    button_halt = 1'b1;
    obs_adr.delete();
    obs_dat.delete();
    exp_idx = 0;
    repeat (16) @(negedge raw_clk);
    button_reset = 1'b1;
    assert (reaches_halt)
    else
    begin
      $display("%s: the reference program never reaches HALT.", name);
      error_count++;
    end
    if (stop_early)
    begin
      wait (exp_idx >= 3);
      @(negedge raw_clk);
      button_halt = 1'b0;
    end
    wait (halted);
    repeat (20)
    begin
      @(negedge raw_clk);
      assert (!wb_cyc)
      else
      begin
        $display("%s: a bus cycle started after halt at %0t.", name, $time);
        error_count++;
      end
    end
    if (stop_early)
    begin
      assert (exp_idx < exp_adr.size())
      else
      begin
        $display("%s: the halt button did not stop the core early.", name);
        error_count++;
      end
    end
    else
    begin
      assert (exp_idx == exp_adr.size())
      else
      begin
        $display("%s: saw %0d writes, the reference predicts %0d.",
                 name, exp_idx, exp_adr.size());
        error_count++;
      end
    end
    if (error_count == errors_before)
    begin
      pass_count++;
      $display("%-12s ok, %0d writes checked", name, exp_idx);
    end
    else
    begin
      fail_count++;
      $display("%-12s FAIL, %0d errors", name, error_count - errors_before);
    end
  endtask

  task automatic build_alu_test();
    clear_memory();
    mem[16'h0020] = rand_word();
    mem[16'h0021] = rand_word();
    mem[16'h0022] = rand_word();
    emit_imm(op_lda, 16'h1234);
    emit(mem_op(op_sto, 'h010));
    emit(mem_op(op_lda, 'h020));
    emit(mem_op(op_add, 'h021));
    emit(mem_op(op_sto, 'h011));
    emit_imm(op_sub, rand_word());
    emit(mem_op(op_sto, 'h012));
    emit(mem_op(op_and, 'h022));
    emit(mem_op(op_sto, 'h013));
    emit_imm(op_neq, rand_word());
    emit(mem_op(op_sto, 'h014));
    emit(halt_word);
  endtask

  task automatic build_carry_test();
    logic [15:0] patch;
    clear_memory();
    mem[16'h0032] = rand_word();
    // Set M, then chain a carry and a borrow.
    emit(bit_op(2'b01, 2'b11, 2'b00, cr_m_bit));
    emit_imm(op_lda, 16'hffff);
    emit_imm(op_add, 16'h0001);
    emit_imm(op_add, 16'h0005);
    emit(mem_op(op_sto, 'h030));
    emit_imm(op_lda, 16'h0003);
    emit_imm(op_sub, 16'h0002);
    emit_imm(op_sub, 16'h0009);
    emit(mem_op(op_sto, 'h031));
    emit_imm(op_lda, rand_word());
    emit(mem_op(op_ads, 'h032));
    // Clear M, compare equal, then jump on Z.
    emit(bit_op(2'b01, 2'b11, 2'b01, cr_m_bit));
    emit_imm(op_lda, 16'h0007);
    emit_imm(op_cmp, 16'h0007);
    emit(bit_op(2'b01, 2'b10, 2'b01, cr_z_bit));
    patch = load_adr;
    emit(16'h0000);
    emit(mem_op(op_sto, 'h033));
    emit(halt_word);
    mem[patch] = load_adr;
    emit(mem_op(op_sto, 'h034));
    emit(halt_word);
  endtask

  task automatic build_shift_test();
    logic [1:0] kind;
    clear_memory();
    for (int k = 0; k < 12; k++)
    begin
      kind = (k % 3 == 0) ? 2'b00 : ((k % 3 == 1) ? 2'b10 : 2'b11);
      emit_imm(op_lda, rand_word());
      emit(bit_op(2'b00, (k < 6) ? 2'b00 : 2'b01, kind, rand_word() % 16));
      emit(mem_op(op_sto, 'h040 + k));
    end
    emit(halt_word);
  endtask

  task automatic build_bit_test();
    int          b1;
    int          b2;
    logic [15:0] patch;
    clear_memory();
    b1 = rand_word() % 16;
    b2 = (b1 + 5) % 16;
    emit_imm(op_lda, rand_word());
    emit(bit_op(2'b00, 2'b11, 2'b00, b1));
    emit(bit_op(2'b00, 2'b11, 2'b01, b2));
    emit(mem_op(op_sto, 'h050));
    // Bit b1 is set, so this jumps and flips it to zero.
    emit(bit_op(2'b00, 2'b10, 2'b11, b1));
    patch = load_adr;
    emit(16'h0000);
    emit(mem_op(op_sto, 'h051));
    mem[patch] = load_adr;
    emit(mem_op(op_sto, 'h052));
    emit(bit_op(2'b00, 2'b10, 2'b00, b1));
    patch = load_adr;
    emit(16'h0000);
    emit(mem_op(op_sto, 'h053));
    mem[patch] = load_adr;
    emit(mem_op(op_sto, 'h054));
    // SJM skips the next two words.
    emit_imm(op_lda, 16'h0002);
    emit(16'h1000);
    emit(mem_op(op_sto, 'h055));
    emit(mem_op(op_sto, 'h056));
    emit(mem_op(op_sto, 'h057));
    emit(mem_op(op_jmp, 0));
    patch = load_adr;
    emit(16'h0000);
    emit(mem_op(op_sto, 'h058));
    mem[patch] = load_adr;
    emit(mem_op(op_sto, 'h059));
    emit(halt_word);
  endtask

  task automatic build_halt_test();
    clear_memory();
    emit_imm(op_lda, rand_word());
    emit(mem_op(op_sto, 'h060));
    emit(halt_word);
    emit(mem_op(op_sto, 'h061));
  endtask

  task automatic build_button_test();
    clear_memory();
    for (int k = 0; k < 12; k++)
    begin
      emit_imm(op_lda, rand_word());
      emit(mem_op(op_sto, 'h070 + k));
    end
    emit(halt_word);
  endtask

  initial
  begin
    seed = 32'h7458;
    error_count = 0;
    pass_count = 0;
    fail_count = 0;
    exp_idx = 0;
    wait_left = 0;
    in_cycle = 1'b0;
    button_reset = 1'b0;
    button_halt = 1'b1;
    wb_ack = 1'b0;
    wb_dat_r = 16'd0;
    build_alu_test();
    run_test("alu_ops", 1'b0);
    build_carry_test();
    run_test("carry_chain", 1'b0);
    build_shift_test();
    run_test("shifts", 1'b0);
    build_bit_test();
    run_test("bit_jumps", 1'b0);
    build_halt_test();
    run_test("halt", 1'b0);
    build_button_test();
    run_test("halt_button", 1'b1);
    $display("Tests run %0d, ok %0d, failing %0d", test_count, pass_count, fail_count);
    if (error_count == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

/* f100l_top.sv */
`timescale 1ns/1ps

module f100l_top
#(
  parameter f100l_pkg::word_t reset_pc = 16'h2000
)
(
  input  logic             raw_clk,
  input  logic             button_reset,
  input  logic             button_halt,
  input  logic             wb_ack,
  input  f100l_pkg::word_t wb_dat_r,
  output logic             wb_cyc,
  output logic             wb_stb,
  output logic             wb_we,
  output f100l_pkg::word_t wb_adr,
  output f100l_pkg::word_t wb_dat_w,
  output logic             halted
);
  import f100l_pkg::*;

  // Sequencer to bus master.
  logic        bus_req;
  logic        bus_we;
  word_t       bus_adr;
  word_t       bus_wdata;
  logic        bus_done;
  word_t       bus_rdata;

  // Sequencer to ALU and bit unit.
  word_t       instruction;
  word_t       accum;
  word_t       data;
  word_t       cr;
  word_t       bit_operand;
  logic [16:0] alu_result;
  word_t       cr_next;
  dest_e       dest;
  word_t       bit_result;
  logic        take_jump;
  logic        flag_s;
  logic        flag_z;

  instr_sequencer #(
    .reset_pc (reset_pc)
  ) instr_sequencer_i (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .button_halt  (button_halt),
    .bus_done     (bus_done),
    .bus_rdata    (bus_rdata),
    .alu_result   (alu_result),
    .cr_next      (cr_next),
    .dest         (dest),
    .bit_result   (bit_result),
    .take_jump    (take_jump),
    .flag_s       (flag_s),
    .flag_z       (flag_z),
    .bus_req      (bus_req),
    .bus_we       (bus_we),
    .bus_adr      (bus_adr),
    .bus_wdata    (bus_wdata),
    .instruction  (instruction),
    .accum        (accum),
    .data         (data),
    .cr           (cr),
    .bit_operand  (bit_operand),
    .halted       (halted)
  );

  alu alu_i (
    .instruction (instruction),
    .accum       (accum),
    .data        (data),
    .cr          (cr),
    .alu_result  (alu_result),
    .cr_next     (cr_next),
    .dest        (dest)
  );

  bit_unit bit_unit_i (
    .instruction (instruction),
    .operand     (bit_operand),
    .cr          (cr),
    .bit_result  (bit_result),
    .take_jump   (take_jump),
    .flag_s      (flag_s),
    .flag_z      (flag_z)
  );

  wb_master wb_master_i (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .bus_req      (bus_req),
    .bus_we       (bus_we),
    .bus_adr      (bus_adr),
    .bus_wdata    (bus_wdata),
    .wb_ack       (wb_ack),
    .wb_dat_r     (wb_dat_r),
    .bus_done     (bus_done),
    .bus_rdata    (bus_rdata),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w)
  );

endmodule

/* instr_sequencer.sv */
`timescale 1ns/1ps

module instr_sequencer
#(
  parameter f100l_pkg::word_t reset_pc = 16'h2000
)
(
  input  logic             raw_clk,
  input  logic             button_reset,
  input  logic             button_halt,
  input  logic             bus_done,
  input  f100l_pkg::word_t bus_rdata,
  input  logic [16:0]      alu_result,
  input  f100l_pkg::word_t cr_next,
  input  f100l_pkg::dest_e dest,
  input  f100l_pkg::word_t bit_result,
  input  logic             take_jump,
  input  logic             flag_s,
  input  logic             flag_z,
  output logic             bus_req,
  output logic             bus_we,
  output f100l_pkg::word_t bus_adr,
  output f100l_pkg::word_t bus_wdata,
  output f100l_pkg::word_t instruction,
  output f100l_pkg::word_t accum,
  output f100l_pkg::word_t data,
  output f100l_pkg::word_t cr,
  output f100l_pkg::word_t bit_operand,
  output logic             halted
);
  import f100l_pkg::*;

  seq_state_e state;
  word_t      pc;
  word_t      ea;
  logic       wait_bus;
  logic       do_jump;
  alu_op_e    op;
  logic [1:0] r_mode;
  logic [1:0] s_mode;

  assign op     = alu_op_e'(instruction[15:12]);
  assign r_mode = instruction[9:8];
  assign s_mode = instruction[7:6];

  // Bit operations work on CR when r is 01, otherwise on the accumulator.
  assign bit_operand = (r_mode == 2'b01) ? cr : accum;

  assign halted = (state == st_halted);

  // Every bus state first pulses bus_req, then waits for bus_done.
  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      state    <= st_fetch;
      pc       <= reset_pc;
      accum    <= '0;
      cr       <= '0;
      wait_bus <= 1'b0;
      do_jump  <= 1'b0;
      bus_req  <= 1'b0;
      bus_we   <= 1'b0;
    end
    else
    begin
      bus_req <= 1'b0;
      case (state)
        st_fetch:
        begin
          if (!wait_bus)
          begin
            // Instruction boundary, the halt button is honoured here.
            if (!button_halt)
              state <= st_halted;
            else
            begin
              bus_req  <= 1'b1;
              bus_we   <= 1'b0;
              bus_adr  <= pc;
              pc       <= pc + 16'd1;
              wait_bus <= 1'b1;
            end
          end
          else if (bus_done)
          begin
            wait_bus    <= 1'b0;
            instruction <= bus_rdata;
            state       <= st_decode;
          end
        end
        st_decode:
        begin
          case (op)
            op_special:
            begin
              if (instruction[11:10] == 2'b01)
                state <= st_halted;
              else if (instruction[11:10] == 2'b00)
                state <= st_bit_writeback;
              else
                state <= st_fetch;
            end
            op_sjm:
            begin
              // pc already points past the SJM word.
              pc    <= pc + accum;
              state <= st_fetch;
            end
            op_sto, op_ads, op_sbs, op_lda, op_add, op_sub, op_cmp, op_and, op_neq, op_jmp:
            begin
              // Zero short address means the operand follows inline.
              if (instruction[10:0] != 11'd0)
                ea <= {5'd0, instruction[10:0]};
              else
              begin
                ea <= pc;
                pc <= pc + 16'd1;
              end
              state <= st_data_fetch;
            end
            default:
              state <= st_fetch;
          endcase
        end
        st_bit_writeback:
        begin
          if (r_mode == 2'b01)
            cr <= bit_result;
          else
            accum <= bit_result;
          // These win over the whole-word CR write above.
          cr[cr_s_bit] <= flag_s;
          cr[cr_z_bit] <= flag_z;
          do_jump      <= take_jump;
          if (s_mode == 2'b10)
            state <= st_bit_jump_fetch;
          else
            state <= st_fetch;
        end
        st_bit_jump_fetch:
        begin
          if (!wait_bus)
          begin
            bus_req  <= 1'b1;
            bus_we   <= 1'b0;
            bus_adr  <= pc;
            pc       <= pc + 16'd1;
            wait_bus <= 1'b1;
          end
          else if (bus_done)
          begin
            wait_bus <= 1'b0;
            if (do_jump)
              pc <= bus_rdata;
            state <= st_fetch;
          end
        end
        st_data_fetch:
        begin
          if (!wait_bus)
          begin
            bus_req  <= 1'b1;
            bus_we   <= 1'b0;
            bus_adr  <= ea;
            wait_bus <= 1'b1;
          end
          else if (bus_done)
          begin
            wait_bus <= 1'b0;
            data     <= bus_rdata;
            state    <= st_execute;
          end
        end
        st_execute:
        begin
          cr <= cr_next;
          case (dest)
            dest_a:
            begin
              accum <= alu_result[15:0];
              state <= st_fetch;
            end
            dest_pc:
            begin
              pc    <= alu_result[15:0];
              state <= st_fetch;
            end
            dest_ea:
            begin
              bus_wdata <= alu_result[15:0];
              state     <= st_store;
            end
            default:
              state <= st_fetch;
          endcase
        end
        st_store:
        begin
          if (!wait_bus)
          begin
            bus_req  <= 1'b1;
            bus_we   <= 1'b1;
            bus_adr  <= ea;
            wait_bus <= 1'b1;
          end
          else if (bus_done)
          begin
            wait_bus <= 1'b0;
            bus_we   <= 1'b0;
            state    <= st_fetch;
          end
        end
        st_halted:
          state <= st_halted;
        default:
          state <= st_fetch;
      endcase
    end
  end

endmodule

/* bit_unit.sv */
`timescale 1ns/1ps

module bit_unit
(
  input  f100l_pkg::word_t instruction,
  input  f100l_pkg::word_t operand,
  input  f100l_pkg::word_t cr,
  output f100l_pkg::word_t bit_result,
  output logic             take_jump,
  output logic             flag_s,
  output logic             flag_z
);
  import f100l_pkg::*;

  logic [1:0]  r_mode;
  logic [1:0]  s_mode;
  logic [1:0]  j_mode;
  logic [3:0]  bit_sel;
  logic [31:0] rot_right;
  logic [31:0] rot_left;

  assign r_mode  = instruction[9:8];
  assign s_mode  = instruction[7:6];
  assign j_mode  = instruction[5:4];
  assign bit_sel = instruction[3:0];

  // Rotates come out of a doubled copy of the word.
  assign rot_right = {operand, operand} >> bit_sel;
  assign rot_left  = {operand, operand} << bit_sel;

  always_comb
  begin
    bit_result = operand;
    take_jump  = 1'b0;
    case (s_mode)
      2'b00:
        case (j_mode)
          2'b10: bit_result = operand >> bit_sel;
          2'b11: bit_result = rot_right[15:0];
          default: bit_result = $signed(operand) >>> bit_sel;
        endcase
      2'b01:
        // Arithmetic and logical left shifts are the same.
        if (j_mode == 2'b11)
          bit_result = rot_left[31:16];
        else
          bit_result = operand << bit_sel;
      2'b10:
      begin
        take_jump = (operand[bit_sel] == j_mode[0]);
        if (take_jump && j_mode[1])
          bit_result[bit_sel] = ~j_mode[0];
      end
      default:
        bit_result[bit_sel] = ~j_mode[0];
    endcase
  end

  // Only shifts give new S and Z, other operations keep the old ones.
  always_comb
  begin
    if (!s_mode[1])
    begin
      flag_s = bit_result[15];
      flag_z = (bit_result == 16'd0);
    end
    else if (r_mode == 2'b01)
    begin
      flag_s = bit_result[cr_s_bit];
      flag_z = bit_result[cr_z_bit];
    end
    else
    begin
      flag_s = cr[cr_s_bit];
      flag_z = cr[cr_z_bit];
    end
  end

endmodule

/* alu.sv */
`timescale 1ns/1ps

module alu
(
  input  f100l_pkg::word_t instruction,
  input  f100l_pkg::word_t accum,
  input  f100l_pkg::word_t data,
  input  f100l_pkg::word_t cr,
  output logic [16:0]      alu_result,
  output f100l_pkg::word_t cr_next,
  output f100l_pkg::dest_e dest
);
  import f100l_pkg::*;

  alu_op_e     op;
  logic [16:0] sum;
  logic [16:0] diff;
  logic        is_add;
  logic        is_sub;

  assign op = alu_op_e'(instruction[15:12]);

  // With M set the carry chains into the next word.
  assign sum  = {1'b0, data} + {1'b0, accum} + {16'd0, cr[cr_m_bit] & cr[cr_c_bit]};
  // Bit 16 of the difference is a borrow.
  assign diff = {1'b0, data} - {1'b0, accum} - {16'd0, cr[cr_m_bit] & ~cr[cr_c_bit]};

  assign is_add = (op == op_add) || (op == op_ads);
  assign is_sub = (op == op_sub) || (op == op_sbs) || (op == op_cmp);

  always_comb
  begin
    alu_result = {1'b0, data};
    dest       = dest_none;
    case (op)
      op_add: begin alu_result = sum;                   dest = dest_a;  end
      op_ads: begin alu_result = sum;                   dest = dest_ea; end
      op_sub: begin alu_result = diff;                  dest = dest_a;  end
      op_sbs: begin alu_result = diff;                  dest = dest_ea; end
      op_cmp: begin alu_result = diff;                  dest = dest_none; end
      op_and: begin alu_result = {1'b0, accum & data};  dest = dest_a;  end
      op_neq: begin alu_result = {1'b0, accum ^ data};  dest = dest_a;  end
      op_lda: begin alu_result = {1'b0, data};          dest = dest_a;  end
      op_sto: begin alu_result = {1'b0, accum};         dest = dest_ea; end
      op_jmp: begin alu_result = {1'b0, data};          dest = dest_pc; end
      default:
        dest = dest_none;
    endcase
  end

  always_comb
  begin
    cr_next = cr;
    if (op != op_lda)
      cr_next[cr_c_bit] = alu_result[16];
    cr_next[cr_s_bit] = alu_result[15];
    cr_next[cr_z_bit] = (alu_result[15:0] == 16'd0);
    // Signed overflow.
    if (is_add)
      cr_next[cr_v_bit] = (accum[15] == data[15]) && (alu_result[15] != accum[15]);
    else if (is_sub)
      cr_next[cr_v_bit] = (accum[15] != data[15]) && (alu_result[15] == accum[15]);
  end

endmodule

/* wb_master.sv */
`timescale 1ns/1ps

module wb_master
(
  input  logic             raw_clk,
  input  logic             button_reset,
  input  logic             bus_req,
  input  logic             bus_we,
  input  f100l_pkg::word_t bus_adr,
  input  f100l_pkg::word_t bus_wdata,
  input  logic             wb_ack,
  input  f100l_pkg::word_t wb_dat_r,
  output logic             bus_done,
  output f100l_pkg::word_t bus_rdata,
  output logic             wb_cyc,
  output logic             wb_stb,
  output logic             wb_we,
  output f100l_pkg::word_t wb_adr,
  output f100l_pkg::word_t wb_dat_w
);

  logic busy;

  // One classic cycle at a time, cyc and stb move together.
  assign wb_cyc = busy;
  assign wb_stb = busy;

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      busy     <= 1'b0;
      wb_we    <= 1'b0;
      bus_done <= 1'b0;
    end
    else
    begin
      bus_done <= 1'b0;
      if (busy)
      begin
        if (wb_ack)
        begin
          busy     <= 1'b0;
          wb_we    <= 1'b0;
          bus_done <= 1'b1;
        end
      end
      else if (bus_req)
      begin
        busy  <= 1'b1;
        wb_we <= bus_we;
      end
    end
  end

  always_ff @(posedge raw_clk)
  begin
    if (!busy && bus_req)
    begin
      wb_adr   <= bus_adr;
      wb_dat_w <= bus_wdata;
    end
    // Read data is valid alongside bus_done.
    if (busy && wb_ack)
      bus_rdata <= wb_dat_r;
  end

endmodule

/* f100l_pkg.sv */
package f100l_pkg;

  // Width of every data and address word.
  localparam int data_width = 16;

  typedef logic [data_width-1:0] word_t;

  // Upper instruction nibble, F100-L encoding.
  // Nibbles 2, 3, 7 and 4'he are not decoded by this core.
  typedef enum logic [3:0] {
    op_special = 4'h0,
    op_sjm     = 4'h1,
    op_sto     = 4'h4,
    op_ads     = 4'h5,
    op_sbs     = 4'h6,
    op_lda     = 4'h8,
    op_add     = 4'h9,
    op_sub     = 4'ha,
    op_cmp     = 4'hb,
    op_and     = 4'hc,
    op_neq     = 4'hd,
    op_jmp     = 4'hf
  } alu_op_e;

  // Where an ALU result is sent.
  typedef enum logic [1:0] {
    dest_none = 2'd0,
    dest_a    = 2'd1,
    dest_pc   = 2'd2,
    dest_ea   = 2'd3
  } dest_e;

  // Instruction sequencer states.
  typedef enum logic [2:0] {
    st_fetch          = 3'd0,
    st_decode         = 3'd1,
    st_bit_jump_fetch = 3'd2,
    st_bit_writeback  = 3'd3,
    st_data_fetch     = 3'd4,
    st_execute        = 3'd5,
    st_store          = 3'd6,
    st_halted         = 3'd7
  } seq_state_e;

  // Condition register flag positions.
  localparam int cr_f_bit = 6;
  localparam int cr_m_bit = 5;
  localparam int cr_c_bit = 4;
  localparam int cr_s_bit = 3;
  localparam int cr_v_bit = 2;
  localparam int cr_z_bit = 1;
  localparam int cr_i_bit = 0;

endpackage
